/* design/board_mon_pkg.sv */
// Board monitor shared widths, register map, reset counts and sensor conversion constants
`default_nettype none

package board_mon_pkg;

  // Temperature sensor and Celsius value widths
  localparam int TSD_CODE_W = 8;
  localparam int CELSIUS_W  = 7;

  // Code that reads as 0 C, and the top of the display range
  localparam logic [TSD_CODE_W-1:0] TSD_OFFSET  = 8'd128;
  localparam logic [CELSIUS_W-1:0]  CELSIUS_MAX = 7'd99;

  // Sensor clear pulse length in clock cycles
  localparam int TSD_CLEAR_CYCLES = 2;

  // Memory controllers reporting calibration
  localparam int MEM_CHANNELS = 4;

  // Cycles from reset release until the SRAM reset is let go
  localparam int MEM_RST_CYCLES = 256;

  // APB bus widths
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // Register offsets
  localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_THRESH  = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_TEMP    = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_MEMSTAT = 8'h0C;

  // Alarm threshold in degrees after reset
  localparam logic [CELSIUS_W-1:0] THRESH_RESET = 7'd85;

endpackage

`default_nettype wire

/* design/temp_if.sv */
// Temperature sample bus from the sensor sampler to the register block and display
`timescale 1ns/1ps
`default_nettype none

interface temp_if;
  import board_mon_pkg::*;

  // One-cycle pulse when a new sample is captured
  logic                  valid;
  logic [TSD_CODE_W-1:0] code;
  logic [CELSIUS_W-1:0]  celsius;
  // Over-threshold flag, owned by the register block
  logic                  alarm;

  modport sampler (
    output valid,
    output code,
    output celsius
  );

  modport consumer (
    input  valid,
    input  code,
    input  celsius,
    output alarm
  );

endinterface

`default_nettype wire

/* design/tsd_sampler.sv */
// On-die temperature sensor sequencer with code capture and Celsius conversion
`timescale 1ns/1ps
`default_nettype none

module tsd_sampler (
  input  logic                                 OSC_50_B4A,
  input  logic                                 rst_n_i,
  input  logic                                 sample_en_i,
  input  logic                                 ts_done_i,
  input  logic [board_mon_pkg::TSD_CODE_W-1:0] ts_out_i,
  output logic                                 ts_enable_o,
  output logic                                 ts_clear_o,
  temp_if.sampler                              temp_bus
);
  import board_mon_pkg::*;

  // Idle when both flops are low, clear or convert otherwise
  logic                                    clear_q;
  logic                                    enable_q;
  logic [$clog2(TSD_CLEAR_CYCLES + 1)-1:0] clr_cnt_q;
  logic                                    valid_q;
  logic [TSD_CODE_W-1:0]                   code_q;
  logic [CELSIUS_W-1:0]                    celsius_q;
  logic [TSD_CODE_W-1:0]                   diff;
  logic [CELSIUS_W-1:0]                    celsius_d;

  // Codes below the offset read as 0, the top end saturates
  always_comb begin
    diff = ts_out_i - TSD_OFFSET;
    if (ts_out_i < TSD_OFFSET) begin
      celsius_d = '0;
    end else if (diff > TSD_CODE_W'(CELSIUS_MAX)) begin
      celsius_d = CELSIUS_MAX;
    end else begin
      celsius_d = diff[CELSIUS_W-1:0];
    end
  end

  always_ff @(posedge OSC_50_B4A or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clear_q   <= 1'b0;
      enable_q  <= 1'b0;
      clr_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else if (!sample_en_i) begin
      clear_q   <= 1'b0;
      enable_q  <= 1'b0;
      clr_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (enable_q) begin
        // Conversion finished, go straight back to clear
        if (ts_done_i) begin
          enable_q  <= 1'b0;
          clear_q   <= 1'b1;
          clr_cnt_q <= '0;
          valid_q   <= 1'b1;
        end
      end else if (clear_q) begin
        if (clr_cnt_q == $bits(clr_cnt_q)'(TSD_CLEAR_CYCLES - 1)) begin
          clear_q  <= 1'b0;
          enable_q <= 1'b1;
        end else begin
          clr_cnt_q <= clr_cnt_q + 1'b1;
        end
      end else begin
        clear_q   <= 1'b1;
        clr_cnt_q <= '0;
      end
    end
  end

  always_ff @(posedge OSC_50_B4A) begin
    if (sample_en_i && enable_q && ts_done_i) begin
      code_q    <= ts_out_i;
      celsius_q <= celsius_d;
    end
  end

  // Gated so the sensor sees a stop as soon as sampling is disabled
  assign ts_clear_o  = clear_q & sample_en_i;
  assign ts_enable_o = enable_q & sample_en_i;

  assign temp_bus.valid   = valid_q;
  assign temp_bus.code    = code_q;
  assign temp_bus.celsius = celsius_q;

  a_clear_enable_excl: assert property (
    @(posedge OSC_50_B4A) disable iff (!rst_n_i) !(ts_enable_o && ts_clear_o)
  ) else $error("Sensor clear and enable both high");

endmodule

`default_nettype wire

/* design/mem_bringup.sv */
// External SRAM reset release and memory calibration status synchronizer
`timescale 1ns/1ps
`default_nettype none

module mem_bringup (
  input  logic                                   OSC_50_B4A,
  input  logic                                   rst_n_i,
  input  logic [board_mon_pkg::MEM_CHANNELS-1:0] mem_cal_done_i,
  input  logic [board_mon_pkg::MEM_CHANNELS-1:0] mem_cal_fail_i,
  output logic                                   sram_rst_n_o,
  output logic                                   sram_released_o,
  output logic [board_mon_pkg::MEM_CHANNELS-1:0] cal_done_o,
  output logic [board_mon_pkg::MEM_CHANNELS-1:0] cal_fail_o,
  output logic [board_mon_pkg::MEM_CHANNELS-1:0] led_o
);
  import board_mon_pkg::*;

  logic [$clog2(MEM_RST_CYCLES)-1:0] rel_cnt_q;
  logic                              sram_rst_n_q;
  logic [2*MEM_CHANNELS-1:0]         meta_q;
  logic [2*MEM_CHANNELS-1:0]         sync_q;

  // SRAM reset lets go on the last count and then holds
  always_ff @(posedge OSC_50_B4A or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rel_cnt_q    <= '0;
      sram_rst_n_q <= 1'b0;
    end else if (rel_cnt_q == $bits(rel_cnt_q)'(MEM_RST_CYCLES - 1)) begin
      sram_rst_n_q <= 1'b1;
    end else begin
      rel_cnt_q <= rel_cnt_q + 1'b1;
    end
  end

  // Calibration flags come from other clock domains
  always_ff @(posedge OSC_50_B4A or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= {mem_cal_fail_i, mem_cal_done_i};
      sync_q <= meta_q;
    end
  end

  assign sram_rst_n_o    = sram_rst_n_q;
  assign sram_released_o = sram_rst_n_q;
  assign cal_done_o      = sync_q[MEM_CHANNELS-1:0];
  assign cal_fail_o      = sync_q[2*MEM_CHANNELS-1:MEM_CHANNELS];

  // LED on for a channel that calibrated cleanly
  assign led_o = cal_done_o & ~cal_fail_o;

  a_sram_rst_hold: assert property (
    @(posedge OSC_50_B4A) disable iff (!rst_n_i) sram_rst_n_o |=> sram_rst_n_o
  ) else $error("SRAM reset reasserted outside of system reset");

endmodule

`default_nettype wire

/* design/board_mon_regs.sv */
// APB register block for sampling control, alarm threshold, temperature and memory status
`timescale 1ns/1ps
`default_nettype none

module board_mon_regs (
  input  logic                                   OSC_50_B4A,
  input  logic                                   rst_n_i,
  input  logic                                   psel_i,
  input  logic                                   penable_i,
  input  logic                                   pwrite_i,
  input  logic [board_mon_pkg::APB_ADDR_W-1:0]   paddr_i,
  input  logic [board_mon_pkg::APB_DATA_W-1:0]   pwdata_i,
  output logic [board_mon_pkg::APB_DATA_W-1:0]   prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o,
  input  logic                                   sram_released_i,
  input  logic [board_mon_pkg::MEM_CHANNELS-1:0] cal_done_i,
  input  logic [board_mon_pkg::MEM_CHANNELS-1:0] cal_fail_i,
  output logic                                   sample_en_o,
  temp_if.consumer                               temp_bus
);
  import board_mon_pkg::*;

  logic                  access;
  logic                  addr_hit;
  logic                  sample_en_q;
  logic [CELSIUS_W-1:0]  thresh_q;
  logic [CELSIUS_W-1:0]  celsius_q;
  logic [TSD_CODE_W-1:0] code_q;
  logic                  seen_q;
  logic                  alarm_q;
  logic [APB_DATA_W-1:0] rdata;

  // Zero wait states, everything completes in the access phase
  assign access   = psel_i & penable_i;
  assign addr_hit = (paddr_i == REG_CTRL) || (paddr_i == REG_THRESH) ||
                    (paddr_i == REG_TEMP) || (paddr_i == REG_MEMSTAT);

  always_ff @(posedge OSC_50_B4A or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sample_en_q <= 1'b0;
      thresh_q    <= THRESH_RESET;
    end else if (access && pwrite_i) begin
      if (paddr_i == REG_CTRL) begin
        sample_en_q <= pwdata_i[0];
      end else if (paddr_i == REG_THRESH) begin
        thresh_q <= pwdata_i[CELSIUS_W-1:0];
      end
    end
  end

  // Latest sample, and alarm re-evaluated on every new one
  always_ff @(posedge OSC_50_B4A or negedge rst_n_i) begin
    if (!rst_n_i) begin
      celsius_q <= '0;
      code_q    <= '0;
      seen_q    <= 1'b0;
      alarm_q   <= 1'b0;
    end else if (temp_bus.valid) begin
      celsius_q <= temp_bus.celsius;
      code_q    <= temp_bus.code;
      seen_q    <= 1'b1;
      alarm_q   <= (temp_bus.celsius >= thresh_q);
    end
  end

  always_comb begin
    rdata = '0;
    if (paddr_i == REG_CTRL) begin
      rdata[0] = sample_en_q;
    end else if (paddr_i == REG_THRESH) begin
      rdata[CELSIUS_W-1:0] = thresh_q;
    end else if (paddr_i == REG_TEMP) begin
      rdata[CELSIUS_W-1:0]  = celsius_q;
      rdata[8 +: TSD_CODE_W] = code_q;
      rdata[16]              = seen_q;
      rdata[17]              = alarm_q;
    end else if (paddr_i == REG_MEMSTAT) begin
      rdata[MEM_CHANNELS-1:0]  = cal_done_i;
      rdata[4 +: MEM_CHANNELS] = cal_fail_i;
      rdata[8]                 = sram_released_i;
    end
  end

  assign prdata_o       = rdata;
  assign pready_o       = 1'b1;
  assign pslverr_o      = access & ~addr_hit;
  assign sample_en_o    = sample_en_q;
  assign temp_bus.alarm = alarm_q;

  // Access phase is only legal inside a selected transfer
  a_apb_enable_sel: assert property (
    @(posedge OSC_50_B4A) disable iff (!rst_n_i) penable_i |-> psel_i
  ) else $error("APB penable without psel");

endmodule

`default_nettype wire

/* design/hex_temp_display.sv */
// Two-digit seven-segment temperature display with alarm on the low decimal point
`timescale 1ns/1ps
`default_nettype none

module hex_temp_display (
  input  logic       OSC_50_B4A,
  input  logic       rst_n_i,
  temp_if.consumer   temp_bus,
  output logic [6:0] hex0_d_o,
  output logic       hex0_dp_o,
  output logic [6:0] hex1_d_o,
  output logic       hex1_dp_o
);
  import board_mon_pkg::*;

  logic [CELSIUS_W-1:0] celsius_q;
  logic                 shown_q;
  logic [3:0]           tens;
  logic [3:0]           ones;

  // Active low segments, gfedcba
  function automatic logic [6:0] seg7(input logic [3:0] digit);
    case (digit)
      4'd0:    seg7 = 7'h40;
      4'd1:    seg7 = 7'h79;
      4'd2:    seg7 = 7'h24;
      4'd3:    seg7 = 7'h30;
      4'd4:    seg7 = 7'h19;
      4'd5:    seg7 = 7'h12;
      4'd6:    seg7 = 7'h02;
      4'd7:    seg7 = 7'h78;
      4'd8:    seg7 = 7'h00;
      4'd9:    seg7 = 7'h10;
      default: seg7 = 7'h7f;
    endcase
  endfunction

  always_ff @(posedge OSC_50_B4A or negedge rst_n_i) begin
    if (!rst_n_i) begin
      celsius_q <= '0;
      shown_q   <= 1'b0;
    end else if (temp_bus.valid) begin
      celsius_q <= temp_bus.celsius;
      shown_q   <= 1'b1;
    end
  end

  // Value is capped at 99 upstream so both digits fit
  assign tens = 4'(celsius_q / CELSIUS_W'(10));
  assign ones = 4'(celsius_q % CELSIUS_W'(10));

  // Blank until the first sample arrives
  assign hex1_d_o = shown_q ? seg7(tens) : 7'h7f;
  assign hex0_d_o = shown_q ? seg7(ones) : 7'h7f;

  assign hex0_dp_o = ~temp_bus.alarm;
  assign hex1_dp_o = 1'b1;

endmodule

`default_nettype wire

/* design/board_mon_top.sv */
// Board bring-up monitor top level joining the sensor, memory, register and display blocks
`timescale 1ns/1ps
`default_nettype none

module board_mon_top (
  input  logic                                   OSC_50_B4A,
  input  logic                                   rst_n_i,
  input  logic                                   ts_done_i,
  input  logic [board_mon_pkg::TSD_CODE_W-1:0]   ts_out_i,
  input  logic [board_mon_pkg::MEM_CHANNELS-1:0] mem_cal_done_i,
  input  logic [board_mon_pkg::MEM_CHANNELS-1:0] mem_cal_fail_i,
  input  logic                                   psel_i,
  input  logic                                   penable_i,
  input  logic                                   pwrite_i,
  input  logic [board_mon_pkg::APB_ADDR_W-1:0]   paddr_i,
  input  logic [board_mon_pkg::APB_DATA_W-1:0]   pwdata_i,
  output logic                                   ts_enable_o,
  output logic                                   ts_clear_o,
  output logic                                   sram_rst_n_o,
  output logic [board_mon_pkg::MEM_CHANNELS-1:0] led_o,
  output logic [board_mon_pkg::APB_DATA_W-1:0]   prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o,
  output logic [6:0]                             hex0_d_o,
  output logic [6:0]                             hex1_d_o,
  output logic                                   hex0_dp_o,
  output logic                                   hex1_dp_o
);
  import board_mon_pkg::*;

  logic                    sample_en;
  logic                    sram_released;
  logic [MEM_CHANNELS-1:0] cal_done;
  logic [MEM_CHANNELS-1:0] cal_fail;

  temp_if temp_bus ();

  // Input side
  tsd_sampler u_tsd_sampler (
    .OSC_50_B4A  (OSC_50_B4A),
    .rst_n_i     (rst_n_i),
    .sample_en_i (sample_en),
    .ts_done_i   (ts_done_i),
    .ts_out_i    (ts_out_i),
    .ts_enable_o (ts_enable_o),
    .ts_clear_o  (ts_clear_o),
    .temp_bus    (temp_bus)
  );

  mem_bringup u_mem_bringup (
    .OSC_50_B4A      (OSC_50_B4A),
    .rst_n_i         (rst_n_i),
    .mem_cal_done_i  (mem_cal_done_i),
    .mem_cal_fail_i  (mem_cal_fail_i),
    .sram_rst_n_o    (sram_rst_n_o),
    .sram_released_o (sram_released),
    .cal_done_o      (cal_done),
    .cal_fail_o      (cal_fail),
    .led_o           (led_o)
  );

  board_mon_regs u_regs (
    .OSC_50_B4A      (OSC_50_B4A),
    .rst_n_i         (rst_n_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .sram_released_i (sram_released),
    .cal_done_i      (cal_done),
    .cal_fail_i      (cal_fail),
    .sample_en_o     (sample_en),
    .temp_bus        (temp_bus)
  );

  // Output side
  hex_temp_display u_display (
    .OSC_50_B4A (OSC_50_B4A),
    .rst_n_i    (rst_n_i),
    .temp_bus   (temp_bus),
    .hex0_d_o   (hex0_d_o),
    .hex0_dp_o  (hex0_dp_o),
    .hex1_d_o   (hex1_d_o),
    .hex1_dp_o  (hex1_dp_o)
  );

endmodule

`default_nettype wire

/* tb/board_mon_tb.sv */
// Board monitor testbench with a sensor model, APB driver and checking assertions
`timescale 1ns/1ps
`default_nettype none

module board_mon_tb;
  import board_mon_pkg::*;

  // Active low segments gfedcba for digits 0 to 9
  localparam logic [6:0] SEG [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                      7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
  localparam logic [7:0] CODES [7] = '{8'd40, 8'd128, 8'd165, 8'd200, 8'd227, 8'd228, 8'd255};

  logic OSC_50_B4A;
  logic rst_n;
  logic ts_done;
  logic [TSD_CODE_W-1:0] ts_out;
  logic [MEM_CHANNELS-1:0] cal_done;
  logic [MEM_CHANNELS-1:0] cal_fail;
  logic psel;
  logic penable;
  logic pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  logic ts_enable;
  logic ts_clear;
  logic sram_rst_n;
  logic [MEM_CHANNELS-1:0] led;
  logic [APB_DATA_W-1:0] prdata;
  logic pready;
  logic pslverr;
  logic [6:0] hex0_d;
  logic [6:0] hex1_d;
  logic hex0_dp;
  logic hex1_dp;
  logic [TSD_CODE_W-1:0] next_code;
  logic [TSD_CODE_W-1:0] taken_code;
  int samples_taken = 0;
  int edges_since_rst = 0;
  int thresh_model;

  board_mon_top u_dut (
    .OSC_50_B4A(OSC_50_B4A), .rst_n_i(rst_n), .ts_done_i(ts_done), .ts_out_i(ts_out),
    .mem_cal_done_i(cal_done), .mem_cal_fail_i(cal_fail), .psel_i(psel),
    .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata),
    .ts_enable_o(ts_enable), .ts_clear_o(ts_clear), .sram_rst_n_o(sram_rst_n),
    .led_o(led), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .hex0_d_o(hex0_d), .hex1_d_o(hex1_d), .hex0_dp_o(hex0_dp), .hex1_dp_o(hex1_dp)
  );

  initial begin
    OSC_50_B4A = 1'b0;
    forever #2 OSC_50_B4A = ~OSC_50_B4A;
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      stop_run($sformatf("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp));
  endtask

  function automatic int expected_celsius(input int code);
    if (code < int'(TSD_OFFSET)) return 0;
    if (code - int'(TSD_OFFSET) > int'(CELSIUS_MAX)) return int'(CELSIUS_MAX);
    return code - int'(TSD_OFFSET);
  endfunction

  // One zero wait state transfer, sampled in the access phase
  task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata, output logic err);
    @(posedge OSC_50_B4A);
    #1;
    psel = 1'b1;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge OSC_50_B4A);
    #1;
    penable = 1'b1;
    @(negedge OSC_50_B4A);
    rdata = prdata;
    err = pslverr;
    @(posedge OSC_50_B4A);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] data, input logic exp_err);
    logic [APB_DATA_W-1:0] rdata;
    logic err;
    apb_access(wr, addr, data, rdata, err);
    check_value($sformatf("pslverr_o at offset 0x%0h", addr), err, exp_err);
    if (!wr && !exp_err) check_value($sformatf("read of offset 0x%0h", addr), rdata, data);
  endtask

  task automatic sample_and_check(input logic [TSD_CODE_W-1:0] code);
    int start;
    int waited;
    int exp_c;
    logic alarm;
    exp_c = expected_celsius(code);
    alarm = (exp_c >= thresh_model);
    @(negedge OSC_50_B4A);
    next_code = code;
    start = samples_taken;
    waited = 0;
    while (!(samples_taken != start && taken_code == code)) begin
      @(negedge OSC_50_B4A);
      waited++;
      if (waited > 200) stop_run($sformatf("Timeout waiting for a sample of code %0d", code));
    end
    check_access(1'b0, REG_TEMP, exp_c | (32'(code) << 8) | (1 << 16) | (32'(alarm) << 17), 0);
    check_value("hex1_d_o", hex1_d, SEG[exp_c / 10]);
    check_value("hex0_d_o", hex0_d, SEG[exp_c % 10]);
    check_value("hex0_dp_o", hex0_dp, !alarm);
  endtask

  // Sensor answers enable with done and a code after 1 to 20 cycles
  initial begin
    int delay;
    delay = 0;
    ts_done = 1'b0;
    ts_out = '0;
    forever begin
      @(posedge OSC_50_B4A);
      #1;
      if (!ts_enable) begin
        if (ts_done) begin
          samples_taken++;
          taken_code = ts_out;
        end
        ts_done = 1'b0;
        delay = 0;
      end else if (!ts_done) begin
        if (delay == 0) delay = $urandom_range(20, 1);
        delay--;
        if (delay == 0) begin
          ts_done = 1'b1;
          ts_out = next_code;
        end
      end
    end
  end

  always @(posedge OSC_50_B4A) begin
    if (rst_n) edges_since_rst <= edges_since_rst + 1;
  end

  // SRAM reset must let go on exactly the 256th edge after reset
  always @(negedge OSC_50_B4A) begin
    check_value("sram_rst_n_o", sram_rst_n, rst_n && (edges_since_rst >= MEM_RST_CYCLES));
  end

  a_clear_enable: assert property (@(posedge OSC_50_B4A) disable iff (!rst_n)
    !(ts_enable && ts_clear)) else stop_run("Sensor clear and enable were high together");
  a_pready: assert property (@(posedge OSC_50_B4A) pready && hex1_dp)
    else stop_run("pready_o or hex1_dp_o went low");

  initial begin
    int waited;
    logic [3:0] d;
    logic [3:0] f;
    logic [3:0] led_prev;
    void'($urandom(32'hf81d1b7c));
    rst_n = 1'b0;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    cal_done = '0;
    cal_fail = '0;
    next_code = '0;
    thresh_model = int'(THRESH_RESET);
    repeat (2) @(posedge OSC_50_B4A);
    #1;
    rst_n = 1'b1;
    @(negedge OSC_50_B4A);
    check_value("ts_enable_o", ts_enable, 0);
    check_value("ts_clear_o", ts_clear, 0);
    check_value("led_o", led, 0);
    check_value("pslverr_o", pslverr, 0);
    check_value("hex1_d_o", hex1_d, 7'h7f);
    check_value("hex0_d_o", hex0_d, 7'h7f);
    check_access(1'b0, REG_CTRL, 0, 0);
    check_access(1'b0, REG_THRESH, THRESH_RESET, 0);
    // No sample seen and SRAM still held in reset
    check_access(1'b0, REG_TEMP, 0, 0);
    check_access(1'b0, REG_MEMSTAT, 0, 0);
    waited = 0;
    while (!sram_rst_n) begin
      @(negedge OSC_50_B4A);
      waited++;
      if (waited > 2 * MEM_RST_CYCLES) stop_run("Timeout waiting for SRAM reset release");
    end
    check_access(1'b1, REG_CTRL, 1, 0);
    foreach (CODES[i]) sample_and_check(CODES[i]);
    repeat (6) sample_and_check(8'($urandom));
    // Alarm threshold lowered to 50 degrees
    check_access(1'b1, REG_THRESH, 50, 0);
    thresh_model = 50;
    sample_and_check(8'd178);
    sample_and_check(8'd177);
    sample_and_check(8'd240);
    sample_and_check(8'd100);
    led_prev = '0;
    repeat (8) begin
      d = 4'($urandom);
      f = 4'($urandom);
      @(posedge OSC_50_B4A);
      #1;
      cal_done = d;
      cal_fail = f;
      // Still the old pattern after the first synchronizer stage
      @(posedge OSC_50_B4A);
      @(negedge OSC_50_B4A);
      check_value("led_o one cycle after a change", led, led_prev);
      @(posedge OSC_50_B4A);
      @(negedge OSC_50_B4A);
      check_value("led_o", led, d & ~f);
      led_prev = d & ~f;
      check_access(1'b0, REG_MEMSTAT, d | (32'(f) << 4) | (1 << 8), 0);
    end
    check_access(1'b0, 8'h10, 0, 1);
    check_access(1'b1, 8'h03, 32'h5a, 1);
    check_access(1'b1, REG_TEMP, 32'hffff_ffff, 0);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
design/board_mon_pkg.sv
design/temp_if.sv
design/tsd_sampler.sv
design/mem_bringup.sv
design/board_mon_regs.sv
design/hex_temp_display.sv
design/board_mon_top.sv
tb/board_mon_tb.sv

/* Bender.yml */
package:
  name: board_mon

sources:
  - design/board_mon_pkg.sv
  - design/temp_if.sv
  - design/tsd_sampler.sv
  - design/mem_bringup.sv
  - design/board_mon_regs.sv
  - design/hex_temp_display.sv
  - design/board_mon_top.sv
  - target: simulation
    files:
      - tb/board_mon_tb.sv
